// File: src/mac_tx_pkg.sv
////////////////////////////////////////
// Shared types and frame constants for the Ethernet MAC transmit path
////////////////////////////////////////

package mac_tx_pkg;

	////////////////////////////////////////
	// Data widths
	////////////////////////////////////////

	// One byte of frame data on the byte side
	typedef logic [7:0] byte_t;

	// One MII nibble, the unit sent per clock on the wire
	typedef logic [3:0] nibble_t;

	// Running CRC-32 register
	typedef logic [31:0] crc_t;

	////////////////////////////////////////
	// CRC-32 constants
	////////////////////////////////////////

	// Bit-reversed form of the IEEE 802.3 polynomial 0x04C11DB7
	localparam crc_t CRC_POLY_REFL = 32'hedb8_8320;
	localparam crc_t CRC_INIT = 32'hffff_ffff;

	////////////////////////////////////////
	// Frame layout
	////////////////////////////////////////

	// Shortest frame before the FCS goes on, 64 bytes on the wire with it
	localparam int MIN_FRAME_BYTES = 60;
	// Preamble length in nibbles, each one of value 5
	localparam int PREAMBLE_NIBBLES = 15;
	// Upper half of the SFD byte, the nibble that closes the preamble
	localparam nibble_t SFD_NIBBLE = 4'hd;
	// Inter-frame gap, 96 bit times at 4 bits per clock
	localparam int IFG_NIBBLES = 24;
	localparam int FCS_NIBBLES = 8;

	// Framer states, PREAMBLE also covers the SFD nibble
	typedef enum logic [1:0] {
		IDLE,
		PREAMBLE,
		DATA,
		GAP
	} framer_state_t;

endpackage

// File: src/tx_pad.sv
////////////////////////////////////////
// Byte stage that pads short frames with zeros to the minimum length
////////////////////////////////////////

`timescale 1ns/10ps

module tx_pad (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_cancel,
	input  logic               i_valid,
	output logic               o_ready,
	input  mac_tx_pkg::byte_t  i_data,
	input  logic               i_last,
	output logic               o_valid,
	input  logic               i_ready,
	output mac_tx_pkg::byte_t  o_data,
	output logic               o_last
);

	// Bytes of the current frame already taken, saturating at the minimum
	logic [$clog2(mac_tx_pkg::MIN_FRAME_BYTES + 1)-1:0] count;
	// High while zero bytes are being generated after a short frame
	logic fill;

	logic load;
	logic take;
	logic fill_step;
	logic short_end;
	logic fill_end;
	logic count_sat;

	// The output register can take a new byte when empty or draining now
	assign load = !o_valid || i_ready;
	// The source is held off while padding and during an abort
	assign o_ready = !fill && load && !i_cancel;
	assign take = i_valid && o_ready;
	assign fill_step = fill && load && !i_cancel;

	// A last byte below this count means the frame is short
	assign short_end = int'(count) < mac_tx_pkg::MIN_FRAME_BYTES - 1;
	// The pad byte produced at this count is byte 60
	assign fill_end = int'(count) == mac_tx_pkg::MIN_FRAME_BYTES - 1;
	assign count_sat = int'(count) == mac_tx_pkg::MIN_FRAME_BYTES;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid <= 1'b0;
			o_last <= 1'b0;
			fill <= 1'b0;
			count <= '0;
		end
		else if (i_cancel)
		begin
			// Abort from the framer drops whatever frame is in progress
			o_valid <= 1'b0;
			o_last <= 1'b0;
			fill <= 1'b0;
			count <= '0;
		end
		else if (fill_step)
		begin
			o_valid <= 1'b1;
			o_last <= fill_end;
			if (fill_end)
			begin
				fill <= 1'b0;
				count <= '0;
			end
			else
				count <= count + 1'b1;
		end
		else if (take)
		begin
			o_valid <= 1'b1;
			if (i_last && short_end)
			begin
				// Last moves to the final pad byte
				o_last <= 1'b0;
				fill <= 1'b1;
				count <= count + 1'b1;
			end
			else if (i_last)
			begin
				o_last <= 1'b1;
				count <= '0;
			end
			else
			begin
				o_last <= 1'b0;
				if (!count_sat)
					count <= count + 1'b1;
			end
		end
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// Payload register, pad bytes are zero
	always_ff @(posedge i_clk)
	begin
		if (fill_step)
			o_data <= '0;
		else if (take)
			o_data <= i_data;
	end

endmodule

// File: src/tx_nibbler.sv
////////////////////////////////////////
// Splits each byte into two nibbles, low nibble first
////////////////////////////////////////

`timescale 1ns/10ps

module tx_nibbler (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_cancel,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  mac_tx_pkg::byte_t    i_data,
	input  logic                 i_last,
	output logic                 o_valid,
	input  logic                 i_ready,
	output mac_tx_pkg::nibble_t  o_data,
	output logic                 o_last
);

	// Held byte and its last flag
	mac_tx_pkg::byte_t byte_q;
	logic last_q;
	// Zero while the low nibble is on the output, one for the high nibble
	logic phase;

	// A new byte goes in when empty or when the high nibble leaves now
	assign o_ready = (!o_valid || (i_ready && phase)) && !i_cancel;

	assign o_data = phase ? byte_q[7:4] : byte_q[3:0];
	// The frame ends on the high nibble of its last byte
	assign o_last = last_q && phase;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid <= 1'b0;
			phase <= 1'b0;
			last_q <= 1'b0;
		end
		else if (i_cancel)
		begin
			o_valid <= 1'b0;
			phase <= 1'b0;
			last_q <= 1'b0;
		end
		else if (i_valid && o_ready)
		begin
			o_valid <= 1'b1;
			phase <= 1'b0;
			last_q <= i_last;
		end
		else if (o_valid && i_ready)
		begin
			// Low nibble taken, so present the high one next
			if (phase)
				o_valid <= 1'b0;
			phase <= !phase;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_valid && o_ready)
			byte_q <= i_data;
	end

endmodule

// File: src/tx_fcs_append.sv
////////////////////////////////////////
// Nibble stage that computes CRC-32 and appends the inverted FCS
////////////////////////////////////////

`timescale 1ns/10ps

module tx_fcs_append (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_crc_en,
	input  logic                 i_cancel,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  mac_tx_pkg::nibble_t  i_data,
	input  logic                 i_last,
	output logic                 o_valid,
	input  logic                 i_ready,
	output mac_tx_pkg::nibble_t  o_data,
	output logic                 o_last
);

	mac_tx_pkg::crc_t crc;
	mac_tx_pkg::crc_t crc_next;
	// High while the eight FCS nibbles are being shifted out
	logic fcs_mode;
	logic [$clog2(mac_tx_pkg::FCS_NIBBLES)-1:0] fcs_cnt;

	logic load;
	logic take;
	logic fcs_step;
	logic fcs_end;

	// One nibble of the reflected CRC, four bit steps folded into one.
	// Each set bit of the combined nibble adds the polynomial shifted down
	// by the distance from bit 3.
	function automatic mac_tx_pkg::crc_t crc_nibble(
		input mac_tx_pkg::crc_t c,
		input mac_tx_pkg::nibble_t d
	);
		mac_tx_pkg::nibble_t low;
		mac_tx_pkg::crc_t r;
		low = c[3:0] ^ d;
		r = c >> 4;
		for (int i = 0; i < 4; i++)
		begin
			if (low[i])
				r = r ^ (mac_tx_pkg::CRC_POLY_REFL >> (3 - i));
		end
		return r;
	endfunction

	assign crc_next = crc_nibble(crc, i_data);

	assign load = !o_valid || i_ready;
	// No data is taken while the FCS goes out
	assign o_ready = !fcs_mode && load && !i_cancel;
	assign take = i_valid && o_ready;
	assign fcs_step = fcs_mode && load && !i_cancel;
	assign fcs_end = int'(fcs_cnt) == mac_tx_pkg::FCS_NIBBLES - 1;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid <= 1'b0;
			o_last <= 1'b0;
			fcs_mode <= 1'b0;
			fcs_cnt <= '0;
			crc <= mac_tx_pkg::CRC_INIT;
		end
		else if (i_cancel)
		begin
			o_valid <= 1'b0;
			o_last <= 1'b0;
			fcs_mode <= 1'b0;
			fcs_cnt <= '0;
			crc <= mac_tx_pkg::CRC_INIT;
		end
		else if (fcs_step)
		begin
			// Shift the CRC down so the next FCS nibble sits at the bottom
			o_valid <= 1'b1;
			o_last <= fcs_end;
			fcs_cnt <= fcs_cnt + 1'b1;
			if (fcs_end)
			begin
				fcs_mode <= 1'b0;
				fcs_cnt <= '0;
				crc <= mac_tx_pkg::CRC_INIT;
			end
			else
				crc <= crc >> 4;
		end
		else if (take)
		begin
			o_valid <= 1'b1;
			crc <= crc_next;
			if (i_last && i_crc_en)
			begin
				o_last <= 1'b0;
				fcs_mode <= 1'b1;
			end
			else if (i_last)
			begin
				// FCS disabled, the frame ends here and the CRC starts over
				o_last <= 1'b1;
				crc <= mac_tx_pkg::CRC_INIT;
			end
			else
				o_last <= 1'b0;
		end
		else if (i_ready)
			o_valid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (fcs_step)
			o_data <= ~crc[3:0];
		else if (take)
			o_data <= i_data;
	end

endmodule

// File: src/tx_mii_framer.sv
////////////////////////////////////////
// MII framer with preamble, SFD, underrun abort and inter-frame gap
////////////////////////////////////////

`timescale 1ns/10ps

module tx_mii_framer (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  mac_tx_pkg::nibble_t  i_data,
	input  logic                 i_last,
	output logic                 o_cancel,
	output logic                 o_tx_en,
	output logic                 o_tx_er,
	output mac_tx_pkg::nibble_t  o_txd
);

	mac_tx_pkg::framer_state_t state;
	// Counts preamble nibbles in PREAMBLE and gap nibbles in GAP
	logic [$clog2(mac_tx_pkg::IFG_NIBBLES)-1:0] cnt;

	logic sfd_now;
	logic gap_done;

	// Nibbles only flow while the frame body is on the wire
	assign o_ready = state == mac_tx_pkg::DATA;

	// The sixteenth preamble slot carries the SFD nibble
	assign sfd_now = int'(cnt) == mac_tx_pkg::PREAMBLE_NIBBLES;
	assign gap_done = int'(cnt) == mac_tx_pkg::IFG_NIBBLES - 1;

	////////////////////////////////////////
	// State machine and MII output register
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= mac_tx_pkg::IDLE;
			cnt <= '0;
			o_cancel <= 1'b0;
			o_tx_en <= 1'b0;
			o_tx_er <= 1'b0;
			o_txd <= '0;
		end
		else
		begin
			// Cancel is a single-cycle pulse
			o_cancel <= 1'b0;
			case (state)
				mac_tx_pkg::IDLE:
				begin
					o_tx_en <= 1'b0;
					o_tx_er <= 1'b0;
					o_txd <= '0;
					// A waiting nibble starts a new frame
					if (i_valid)
					begin
						state <= mac_tx_pkg::PREAMBLE;
						cnt <= '0;
					end
				end
				mac_tx_pkg::PREAMBLE:
				begin
					o_tx_en <= 1'b1;
					o_tx_er <= 1'b0;
					cnt <= cnt + 1'b1;
					if (sfd_now)
					begin
						o_txd <= mac_tx_pkg::SFD_NIBBLE;
						state <= mac_tx_pkg::DATA;
						cnt <= '0;
					end
					else
						o_txd <= 4'h5;
				end
				mac_tx_pkg::DATA:
				begin
					o_tx_en <= 1'b1;
					if (i_valid)
					begin
						o_tx_er <= 1'b0;
						o_txd <= i_data;
						if (i_last)
						begin
							state <= mac_tx_pkg::GAP;
							cnt <= '0;
						end
					end
					else
					begin
						// Underrun, mark the nibble bad and flush upstream
						o_tx_er <= 1'b1;
						o_txd <= '0;
						o_cancel <= 1'b1;
						state <= mac_tx_pkg::GAP;
						cnt <= '0;
					end
				end
				mac_tx_pkg::GAP:
				begin
					o_tx_en <= 1'b0;
					o_tx_er <= 1'b0;
					o_txd <= '0;
					cnt <= cnt + 1'b1;
					if (gap_done)
					begin
						state <= mac_tx_pkg::IDLE;
						cnt <= '0;
					end
				end
				default:
				begin
					state <= mac_tx_pkg::IDLE;
					cnt <= '0;
					o_tx_en <= 1'b0;
					o_tx_er <= 1'b0;
					o_txd <= '0;
				end
			endcase
		end
	end

endmodule

// File: src/mac_tx_top.sv
////////////////////////////////////////
// Ethernet MAC transmit path from byte stream to MII nibbles
////////////////////////////////////////

`timescale 1ns/10ps

module mac_tx_top (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_crc_en,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  mac_tx_pkg::byte_t    i_data,
	input  logic                 i_last,
	output logic                 o_tx_en,
	output logic                 o_tx_er,
	output mac_tx_pkg::nibble_t  o_txd
);

	// Pad stage output
	logic pad_valid;
	logic pad_ready;
	mac_tx_pkg::byte_t pad_data;
	logic pad_last;

	// Nibbler output
	logic nib_valid;
	logic nib_ready;
	mac_tx_pkg::nibble_t nib_data;
	logic nib_last;

	// FCS stage output
	logic fcs_valid;
	logic fcs_ready;
	mac_tx_pkg::nibble_t fcs_data;
	logic fcs_last;

	// Underrun abort from the framer to every stage before it
	logic cancel;

	tx_pad u_pad (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_cancel (cancel),
		.i_valid  (i_valid),
		.o_ready  (o_ready),
		.i_data   (i_data),
		.i_last   (i_last),
		.o_valid  (pad_valid),
		.i_ready  (pad_ready),
		.o_data   (pad_data),
		.o_last   (pad_last)
	);

	tx_nibbler u_nibbler (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_cancel (cancel),
		.i_valid  (pad_valid),
		.o_ready  (pad_ready),
		.i_data   (pad_data),
		.i_last   (pad_last),
		.o_valid  (nib_valid),
		.i_ready  (nib_ready),
		.o_data   (nib_data),
		.o_last   (nib_last)
	);

	tx_fcs_append u_fcs (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_crc_en (i_crc_en),
		.i_cancel (cancel),
		.i_valid  (nib_valid),
		.o_ready  (nib_ready),
		.i_data   (nib_data),
		.i_last   (nib_last),
		.o_valid  (fcs_valid),
		.i_ready  (fcs_ready),
		.o_data   (fcs_data),
		.o_last   (fcs_last)
	);

	tx_mii_framer u_framer (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_valid  (fcs_valid),
		.o_ready  (fcs_ready),
		.i_data   (fcs_data),
		.i_last   (fcs_last),
		.o_cancel (cancel),
		.o_tx_en  (o_tx_en),
		.o_tx_er  (o_tx_er),
		.o_txd    (o_txd)
	);

endmodule

// File: tests/mac_tx_chk.sv
////////////////////////////////////////
// Protocol assertions on the MII port and the byte input handshake
////////////////////////////////////////

`timescale 1ns/10ps

module mac_tx_chk (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_valid,
	input  logic                 i_ready,
	input  mac_tx_pkg::byte_t    i_data,
	input  logic                 i_last,
	input  logic                 i_tx_en,
	input  logic                 i_tx_er,
	input  mac_tx_pkg::nibble_t  i_txd
);

	// Count of failed assertions
	int fail_cnt = 0;
	// Consecutive idle nibble times on the wire, saturating at the gap length
	logic [4:0] idle_cnt;
	// Position inside the frame head, stops counting past the SFD slot
	logic [4:0] head_cnt;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			// Out of reset the gap counts as already served
			idle_cnt <= 5'(mac_tx_pkg::IFG_NIBBLES);
			head_cnt <= '0;
		end
		else
		begin
			if (i_tx_en)
				idle_cnt <= '0;
			else if (int'(idle_cnt) < mac_tx_pkg::IFG_NIBBLES)
				idle_cnt <= idle_cnt + 1'b1;
			// Restarts on every idle nibble so each frame starts at zero
			if (!i_tx_en)
				head_cnt <= '0;
			else if (int'(head_cnt) <= mac_tx_pkg::PREAMBLE_NIBBLES)
				head_cnt <= head_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// MII rules
	////////////////////////////////////////

	// An error nibble is only legal while a frame is on the wire
	er_needs_en: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_er |-> i_tx_en)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("o_tx_er high while o_tx_en is low");
	end

	// A new frame may only start after the full inter-frame gap
	gap_before_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_tx_en) |-> int'(idle_cnt) >= mac_tx_pkg::IFG_NIBBLES)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("frame started %0d nibble times after the previous one", idle_cnt);
	end

	// The first fifteen nibbles of a frame are all preamble
	preamble_fives: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_en && int'(head_cnt) < mac_tx_pkg::PREAMBLE_NIBBLES |-> i_txd == 4'h5)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("preamble nibble %0d is %h", head_cnt, i_txd);
	end

	// The sixteenth nibble closes the preamble with the SFD
	sfd_slot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_en && int'(head_cnt) == mac_tx_pkg::PREAMBLE_NIBBLES
		|-> i_txd == mac_tx_pkg::SFD_NIBBLE)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("SFD nibble is %h", i_txd);
	end

	////////////////////////////////////////
	// Byte input handshake
	////////////////////////////////////////

	// A stalled byte stays put until the DUT takes it
	input_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_valid && !i_ready |=> i_valid && $stable(i_data) && $stable(i_last))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("byte input changed while stalled");
	end

endmodule

// File: include/crc32_model.svh
////////////////////////////////////////
// Reference CRC-32 and expected MII nibble stream for one frame
////////////////////////////////////////

`ifndef CRC32_MODEL_SVH
`define CRC32_MODEL_SVH

// Bit-serial CRC-32 over one byte, LSB first as it goes on the wire
function automatic mac_tx_pkg::crc_t crc32_byte(
	input mac_tx_pkg::crc_t crc,
	input mac_tx_pkg::byte_t b
);
	mac_tx_pkg::crc_t c;
	c = crc;
	for (int i = 0; i < 8; i++)
	begin
		if (c[0] ^ b[i])
			c = (c >> 1) ^ mac_tx_pkg::CRC_POLY_REFL;
		else
			c = c >> 1;
	end
	return c;
endfunction

// Full wire image: preamble, SFD, padded data low nibble first, then FCS
function automatic void build_expected(
	input mac_tx_pkg::byte_t data[$],
	input bit crc_en,
	output mac_tx_pkg::nibble_t exp_q[$]
);
	mac_tx_pkg::byte_t padded[$];
	mac_tx_pkg::crc_t crc;
	padded = data;
	exp_q = {};
	crc = mac_tx_pkg::CRC_INIT;
	while (padded.size() < mac_tx_pkg::MIN_FRAME_BYTES)
		padded.push_back('0);
	for (int i = 0; i < mac_tx_pkg::PREAMBLE_NIBBLES; i++)
		exp_q.push_back(4'h5);
	exp_q.push_back(mac_tx_pkg::SFD_NIBBLE);
	foreach (padded[i])
	begin
		exp_q.push_back(padded[i][3:0]);
		exp_q.push_back(padded[i][7:4]);
		crc = crc32_byte(crc, padded[i]);
	end
	// The FCS is the complemented CRC, lowest nibble first
	crc = ~crc;
	if (crc_en)
	begin
		for (int k = 0; k < mac_tx_pkg::FCS_NIBBLES; k++)
			exp_q.push_back(crc[4*k +: 4]);
	end
endfunction

`endif

// File: tests/tb_mac_tx.sv
////////////////////////////////////////
// Testbench for the MAC transmit path
// Random frames in, MII nibbles compared with a CRC-32 model
////////////////////////////////////////

`timescale 1ns/10ps

module tb_mac_tx;

	localparam int CLK_PERIOD = 40;
	// Inputs change this long after the rising edge
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 10;
	// Input pause that starves the framer in the abort test
	localparam int STARVE_CYCLES = 10;
	// Bytes sent before that pause
	localparam int ABORT_CUT = 40;
	localparam int N_LONG = 4;
	localparam int N_SHORT = 4;
	localparam int N_NOFCS = 3;
	localparam int N_B2B = 3;

	logic i_clk;
	logic i_rst_n;
	logic i_crc_en;
	logic i_valid;
	logic o_ready;
	mac_tx_pkg::byte_t i_data;
	logic i_last;
	logic o_tx_en;
	logic o_tx_er;
	mac_tx_pkg::nibble_t o_txd;

	// Frame lengths and idle cycles after each frame, fixed before the run
	int frame_len[$];
	int frame_idle[$];
	int next_idx = 0;
	int watchdog_cycles = 0;

	// Expected wire nibbles of all queued frames, and the length of each frame
	mac_tx_pkg::nibble_t exp_q[$];
	int exp_len_q[$];
	int frames_sent = 0;
	int frames_ended = 0;
	int aborts = 0;

	// Monitor state for the frame now on the wire
	bit in_frame = 1'b0;
	bit er_prev = 1'b0;
	int nib_pos = 0;
	int cur_len = 0;

	`include "crc32_model.svh"

	mac_tx_top i_dut (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_crc_en (i_crc_en),
		.i_valid  (i_valid),
		.o_ready  (o_ready),
		.i_data   (i_data),
		.i_last   (i_last),
		.o_tx_en  (o_tx_en),
		.o_tx_er  (o_tx_er),
		.o_txd    (o_txd)
	);

	bind mac_tx_top mac_tx_chk u_chk (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (i_valid),
		.i_ready (o_ready),
		.i_data  (i_data),
		.i_last  (i_last),
		.i_tx_en (o_tx_en),
		.i_tx_er (o_tx_er),
		.i_txd   (o_txd)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped");
	endtask

	// Each step ends just after a rising edge, where inputs are driven
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge i_clk);
			#DRIVE_DLY;
		end
	endtask

	// Ready is read mid-cycle, so the transfer edge is known without a race
	task automatic wait_transfer();
		logic rdy;
		rdy = 1'b0;
		while (!rdy)
		begin
			@(negedge i_clk);
			rdy = o_ready;
			@(posedge i_clk);
			#DRIVE_DLY;
		end
	endtask

	// Waits until every queued frame has left the MII
	task automatic wait_idle();
		while (frames_ended != frames_sent || in_frame)
			idle_cycles(1);
	endtask

	// Fixes all lengths and gaps up front so the watchdog limit is known
	task automatic plan_frames();
		int total;
		int padded;
		for (int i = 0; i < N_LONG; i++)
		begin
			frame_len.push_back($urandom_range(200, 64));
			frame_idle.push_back($urandom_range(30, 0));
		end
		// The shortest and longest short frames, then two random ones
		frame_len.push_back(1);
		frame_len.push_back(mac_tx_pkg::MIN_FRAME_BYTES - 1);
		frame_len.push_back($urandom_range(59, 1));
		frame_len.push_back($urandom_range(59, 1));
		for (int i = 0; i < N_SHORT; i++)
			frame_idle.push_back($urandom_range(30, 0));
		frame_len.push_back($urandom_range(59, 1));
		frame_len.push_back($urandom_range(200, 64));
		frame_len.push_back($urandom_range(59, 1));
		for (int i = 0; i < N_NOFCS; i++)
			frame_idle.push_back($urandom_range(30, 0));
		// Back-to-back frames with no idle time at the source
		for (int i = 0; i < N_B2B; i++)
		begin
			frame_len.push_back($urandom_range(200, 1));
			frame_idle.push_back(0);
		end
		// Aborted frame, then the frame that follows it
		frame_len.push_back(100);
		frame_idle.push_back(STARVE_CYCLES);
		frame_len.push_back($urandom_range(200, 64));
		frame_idle.push_back(0);
		total = RESET_CYCLES + 1000;
		foreach (frame_len[i])
		begin
			padded = (frame_len[i] < mac_tx_pkg::MIN_FRAME_BYTES) ?
				mac_tx_pkg::MIN_FRAME_BYTES : frame_len[i];
			total += padded * 4 + 2 * mac_tx_pkg::PREAMBLE_NIBBLES
				+ mac_tx_pkg::FCS_NIBBLES + mac_tx_pkg::IFG_NIBBLES + frame_idle[i];
		end
		watchdog_cycles = total;
	endtask

	// Queues the model's wire image, then feeds the bytes; a nonzero cut
	// sends only that many bytes and never raises last
	task automatic send_frame(input int len, input int cut);
		mac_tx_pkg::byte_t data[$];
		mac_tx_pkg::nibble_t wire_q[$];
		int n;
		n = (cut > 0) ? cut : len;
		for (int i = 0; i < n; i++)
			data.push_back(mac_tx_pkg::byte_t'($urandom));
		build_expected(data, i_crc_en, wire_q);
		foreach (wire_q[i])
			exp_q.push_back(wire_q[i]);
		exp_len_q.push_back(wire_q.size());
		frames_sent++;
		for (int i = 0; i < n; i++)
		begin
			i_valid = 1'b1;
			i_data = data[i];
			i_last = (cut == 0) && (i == n - 1);
			wait_transfer();
		end
		i_valid = 1'b0;
		i_last = 1'b0;
		i_data = '0;
		// A short frame is being padded now, so the source must be held off
		if (cut == 0 && n < mac_tx_pkg::MIN_FRAME_BYTES)
		begin
			@(negedge i_clk);
			assert (!o_ready)
			else
				abort_run($sformatf("Error at %0d ns: o_ready high while padding",
					$time));
			@(posedge i_clk);
			#DRIVE_DLY;
		end
	endtask

	task automatic send_batch(input int count);
		for (int i = 0; i < count; i++)
		begin
			send_frame(frame_len[next_idx], 0);
			idle_cycles(frame_idle[next_idx]);
			next_idx++;
		end
	endtask

	////////////////////////////////////////
	// MII monitor
	////////////////////////////////////////

	// Outputs move on the rising edge, so the falling edge sees them settled
	always @(negedge i_clk)
	begin
		if (i_dut.u_chk.fail_cnt != 0)
			abort_run("A protocol assertion in the bound checker failed");
		// The error nibble is the last one of an aborted frame
		if (er_prev)
			assert (!o_tx_en)
			else
				abort_run($sformatf("Error at %0d ns: o_tx_en still high after o_tx_er",
					$time));
		if (o_tx_en)
		begin
			if (!in_frame)
			begin
				assert (exp_len_q.size() > 0)
				else
					abort_run($sformatf(
						"Error at %0d ns: o_tx_en rose with no frame queued",
						$time));
				in_frame = 1'b1;
				nib_pos = 0;
				cur_len = exp_len_q.pop_front();
			end
			if (o_tx_er)
			begin
				// Nibbles of the aborted frame that never reach the wire
				while (nib_pos < cur_len)
				begin
					void'(exp_q.pop_front());
					nib_pos++;
				end
				aborts++;
			end
			else
			begin
				assert (nib_pos < cur_len)
				else
					abort_run($sformatf(
						"Error at %0d ns: frame %0d longer than %0d nibbles",
						$time, frames_ended, cur_len));
				assert (o_txd == exp_q[0])
				else
					abort_run($sformatf(
						"Error at %0d ns: o_txd %h, expected %h at nibble %0d of frame %0d",
						$time, o_txd, exp_q[0], nib_pos, frames_ended));
				void'(exp_q.pop_front());
				nib_pos++;
			end
		end
		else if (in_frame)
		begin
			assert (nib_pos == cur_len)
			else
				abort_run($sformatf(
					"Error at %0d ns: frame %0d ended after %0d of %0d nibbles",
					$time, frames_ended, nib_pos, cur_len));
			in_frame = 1'b0;
			frames_ended++;
		end
		er_prev = o_tx_er;
	end

	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge i_clk);
		abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
			watchdog_cycles));
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		i_rst_n = 1'b0;
		i_crc_en = 1'b1;
		i_valid = 1'b0;
		i_data = '0;
		i_last = 1'b0;
		void'($urandom(32'h21dade2c));
		plan_frames();

		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DLY;
		i_rst_n = 1'b1;
		idle_cycles(2);

		// Long and short frames with FCS, short ones get padded
		send_batch(N_LONG);
		send_batch(N_SHORT);

		// FCS off, change the mode only with the pipeline empty
		wait_idle();
		i_crc_en = 1'b0;
		send_batch(N_NOFCS);
		wait_idle();
		i_crc_en = 1'b1;

		// Frames offered back to back are held off by o_ready
		send_batch(N_B2B);
		wait_idle();

		// Starve the framer mid-frame and wait for the abort
		send_frame(frame_len[next_idx], ABORT_CUT);
		idle_cycles(frame_idle[next_idx]);
		next_idx++;
		while (aborts == 0)
			idle_cycles(1);
		// The next frame has to come out with a fresh CRC
		send_batch(1);
		wait_idle();
		idle_cycles(mac_tx_pkg::IFG_NIBBLES);

		assert (exp_q.size() == 0 && exp_len_q.size() == 0)
		else
			abort_run($sformatf("Error at %0d ns: %0d expected nibbles never appeared",
				$time, exp_q.size()));
		assert (aborts == 1)
		else
			abort_run($sformatf("Error at %0d ns: %0d aborts seen, expected one",
				$time, aborts));
		if (frames_ended == frames_sent && i_dut.u_chk.fail_cnt == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			abort_run("The frames seen on the MII do not match the frames sent");
	end

endmodule

// File: build.f
+incdir+include
src/mac_tx_pkg.sv
src/tx_pad.sv
src/tx_nibbler.sv
src/tx_fcs_append.sv
src/tx_mii_framer.sv
src/mac_tx_top.sv
tests/mac_tx_chk.sv
tests/tb_mac_tx.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the MAC transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mac_tx -o sim_mac_tx -f build.f

# A failed run exits nonzero, so keep going and let the log decide
./obj_dir/sim_mac_tx +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log
then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
